// File: hdl/async_fifo_settings.svh
`ifndef ASYNC_FIFO_SETTINGS_SVH
`define ASYNC_FIFO_SETTINGS_SVH

// Build-time sizing of the dual-clock FIFO

// Bits per stored word
`define ASYNC_FIFO_DATA_WIDTH 8

// Depth in words must be a power of two for the pointer wrap bit
`define ASYNC_FIFO_DEPTH 16

// afull set at or above this many words
`define ASYNC_FIFO_AFULL_LEVEL 14

// aempty set at or below this many words
`define ASYNC_FIFO_AEMPTY_LEVEL 2

`endif

// File: hdl/async_fifo_pkg.sv
`default_nettype none

`include "async_fifo_settings.svh"

package async_fifo_pkg;

  localparam int FIFO_ADDR_WIDTH = $clog2(`ASYNC_FIFO_DEPTH);
  localparam int FIFO_PTR_WIDTH  = FIFO_ADDR_WIDTH + 1;  // Extra wrap bit

  typedef logic [`ASYNC_FIFO_DATA_WIDTH-1:0] fifo_data_t;
  typedef logic [FIFO_ADDR_WIDTH-1:0]        fifo_addr_t;

  // Holds binary or Gray depending on where it sits
  typedef logic [FIFO_PTR_WIDTH-1:0]         fifo_ptr_t;

  // Write side status
  typedef struct packed {
    logic full;
    logic afull;
  } fifo_wr_flags_t;

  // Read side status
  typedef struct packed {
    logic empty;
    logic aempty;
  } fifo_rd_flags_t;

endpackage

`default_nettype wire

// File: hdl/fifo_dual_port_ram.sv
`default_nettype none

`include "async_fifo_settings.svh"

module fifo_dual_port_ram (
  input  logic                       wr_clk,
  input  logic                       wr_accept,
  input  async_fifo_pkg::fifo_addr_t wr_addr,
  input  async_fifo_pkg::fifo_data_t wr_data,
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_accept,
  input  async_fifo_pkg::fifo_addr_t rd_addr,
  output async_fifo_pkg::fifo_data_t rd_data
);

  import async_fifo_pkg::*;

  fifo_data_t mem [`ASYNC_FIFO_DEPTH];

  // Write port stores on the accepting edge
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port that holds until the next pop
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/gray_ptr_sync.sv
`default_nettype none

module gray_ptr_sync (
  input  logic                      dst_clk,
  input  logic                      dst_rst_n,
  input  async_fifo_pkg::fifo_ptr_t ptr_gray,
  output async_fifo_pkg::fifo_ptr_t ptr_bin
);

  import async_fifo_pkg::*;

  fifo_ptr_t sync_q1;  // May go metastable
  fifo_ptr_t sync_q2;

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= ptr_gray;
      sync_q2 <= sync_q1;
    end
  end

  // Gray back to binary by a running XOR from the top bit down
  always_comb begin
    ptr_bin[FIFO_PTR_WIDTH-1] = sync_q2[FIFO_PTR_WIDTH-1];
    for (int i = FIFO_PTR_WIDTH - 2; i >= 0; i--) begin
      ptr_bin[i] = ptr_bin[i+1] ^ sync_q2[i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/fifo_wr_ctrl.sv
`default_nettype none

`include "async_fifo_settings.svh"

module fifo_wr_ctrl (
  input  logic                           wr_clk,
  input  logic                           wr_rst_n,
  input  logic                           wr_en,
  input  async_fifo_pkg::fifo_ptr_t      rd_ptr_synced,
  output logic                           wr_accept,
  output async_fifo_pkg::fifo_addr_t     wr_addr,
  output async_fifo_pkg::fifo_ptr_t      wr_ptr_gray,
  output async_fifo_pkg::fifo_wr_flags_t wr_flags
);

  import async_fifo_pkg::*;

  fifo_ptr_t      wr_ptr;
  fifo_ptr_t      wr_ptr_nxt;
  fifo_ptr_t      wr_gray_nxt;
  fifo_ptr_t      rd_ptr_wrapped;
  fifo_ptr_t      wr_count_nxt;
  fifo_wr_flags_t wr_flags_nxt;

  // Writes while full are dropped here
  assign wr_accept = wr_en && !wr_flags.full;

  assign wr_ptr_nxt  = wr_ptr + fifo_ptr_t'(wr_accept);
  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);

  assign wr_addr = wr_ptr[FIFO_ADDR_WIDTH-1:0];

  // Full when one whole lap ahead of the reader
  assign rd_ptr_wrapped = {~rd_ptr_synced[FIFO_PTR_WIDTH-1],
                           rd_ptr_synced[FIFO_PTR_WIDTH-2:0]};

  // Modulo difference gives the fill level including the wrap
  assign wr_count_nxt = wr_ptr_nxt - rd_ptr_synced;

  always_comb begin
    wr_flags_nxt.full  = (wr_ptr_nxt == rd_ptr_wrapped);
    wr_flags_nxt.afull = (wr_count_nxt >= fifo_ptr_t'(`ASYNC_FIFO_AFULL_LEVEL));
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;  // Registered so the crossing sees clean edges
    end
  end

  // Flags land on the same edge as the write that moves them
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_flags <= '{full: 1'b0, afull: 1'b0};
    end else begin
      wr_flags <= wr_flags_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fifo_rd_ctrl.sv
`default_nettype none

`include "async_fifo_settings.svh"

module fifo_rd_ctrl (
  input  logic                           rd_clk,
  input  logic                           rd_rst_n,
  input  logic                           rd_en,
  input  async_fifo_pkg::fifo_ptr_t      wr_ptr_synced,
  output logic                           rd_accept,
  output async_fifo_pkg::fifo_addr_t     rd_addr,
  output async_fifo_pkg::fifo_ptr_t      rd_ptr_gray,
  output async_fifo_pkg::fifo_rd_flags_t rd_flags,
  output logic                           rd_valid
);

  import async_fifo_pkg::*;

  fifo_ptr_t      rd_ptr;
  fifo_ptr_t      rd_ptr_nxt;
  fifo_ptr_t      rd_gray_nxt;
  fifo_ptr_t      rd_count_nxt;
  fifo_rd_flags_t rd_flags_nxt;

  // Reads while empty are ignored
  assign rd_accept = rd_en && !rd_flags.empty;

  assign rd_ptr_nxt  = rd_ptr + fifo_ptr_t'(rd_accept);
  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);

  assign rd_addr = rd_ptr[FIFO_ADDR_WIDTH-1:0];

  // Words left once this read is taken
  assign rd_count_nxt = wr_ptr_synced - rd_ptr_nxt;

  always_comb begin
    rd_flags_nxt.empty  = (rd_ptr_nxt == wr_ptr_synced);  // Includes wrap bit
    rd_flags_nxt.aempty = (rd_count_nxt <= fifo_ptr_t'(`ASYNC_FIFO_AEMPTY_LEVEL));
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // Empty out of reset until the first write crosses over
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_flags <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_flags <= rd_flags_nxt;
    end
  end

  // Lines up with the registered read port
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_accept;
    end
  end

endmodule

`default_nettype wire

// File: hdl/async_fifo.sv
`default_nettype none

module async_fifo (
  input  logic                       wr_clk,
  input  logic                       wr_rst_n,
  input  logic                       wr_en,
  input  async_fifo_pkg::fifo_data_t wr_data,
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_en,
  output async_fifo_pkg::fifo_data_t rd_data,
  output logic                       rd_valid,
  output logic                       full,
  output logic                       afull,
  output logic                       empty,
  output logic                       aempty
);

  import async_fifo_pkg::*;

  // Write domain
  logic           wr_accept;
  fifo_addr_t     wr_addr;
  fifo_ptr_t      wr_ptr_gray;
  fifo_ptr_t      rd_ptr_synced;
  fifo_wr_flags_t wr_flags;

  // Read domain
  logic           rd_accept;
  fifo_addr_t     rd_addr;
  fifo_ptr_t      rd_ptr_gray;
  fifo_ptr_t      wr_ptr_synced;
  fifo_rd_flags_t rd_flags;

  fifo_wr_ctrl wr_ctrl_i (
    .wr_clk        (wr_clk),
    .wr_rst_n      (wr_rst_n),
    .wr_en         (wr_en),
    .rd_ptr_synced (rd_ptr_synced),
    .wr_accept     (wr_accept),
    .wr_addr       (wr_addr),
    .wr_ptr_gray   (wr_ptr_gray),
    .wr_flags      (wr_flags)
  );

  fifo_rd_ctrl rd_ctrl_i (
    .rd_clk        (rd_clk),
    .rd_rst_n      (rd_rst_n),
    .rd_en         (rd_en),
    .wr_ptr_synced (wr_ptr_synced),
    .rd_accept     (rd_accept),
    .rd_addr       (rd_addr),
    .rd_ptr_gray   (rd_ptr_gray),
    .rd_flags      (rd_flags),
    .rd_valid      (rd_valid)
  );

  gray_ptr_sync wr2rd_sync (  // Write pointer into rd_clk
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .ptr_gray  (wr_ptr_gray),
    .ptr_bin   (wr_ptr_synced)
  );

  gray_ptr_sync rd2wr_sync (  // Read pointer into wr_clk
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .ptr_gray  (rd_ptr_gray),
    .ptr_bin   (rd_ptr_synced)
  );

  fifo_dual_port_ram ram_i (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  assign full   = wr_flags.full;
  assign afull  = wr_flags.afull;
  assign empty  = rd_flags.empty;
  assign aempty = rd_flags.aempty;

endmodule

`default_nettype wire

// File: test/async_fifo_assertions.sv
`default_nettype none

module async_fifo_assertions (
  input logic                      wr_clk,
  input logic                      wr_rst_n,
  input logic                      rd_clk,
  input logic                      rd_rst_n,
  input logic                      full,
  input logic                      empty,
  input logic                      rd_valid,
  input async_fifo_pkg::fifo_ptr_t wr_ptr_gray,
  input async_fifo_pkg::fifo_ptr_t rd_ptr_gray
);

  wr_ptr_held: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    full |=> $stable(wr_ptr_gray)
  ) else $error("Write pointer moved while full");

  rd_ptr_held: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    empty |=> $stable(rd_ptr_gray)
  ) else $error("Read pointer moved while empty");

  // Single bit steps keep the synchronizers safe
  wr_gray_step: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
  ) else $error("Write Gray pointer changed by more than one bit");

  rd_gray_step: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1
  ) else $error("Read Gray pointer changed by more than one bit");

  // An accepted read moves the pointer on the edge that raises rd_valid
  rd_valid_follows_accept: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_valid |-> !$stable(rd_ptr_gray)
  ) else $error("rd_valid without an accepted read one cycle before");

endmodule

bind async_fifo async_fifo_assertions assertions_i (
  .wr_clk      (wr_clk),
  .wr_rst_n    (wr_rst_n),
  .rd_clk      (rd_clk),
  .rd_rst_n    (rd_rst_n),
  .full        (full),
  .empty       (empty),
  .rd_valid    (rd_valid),
  .wr_ptr_gray (wr_ptr_gray),
  .rd_ptr_gray (rd_ptr_gray)
);

`default_nettype wire

// File: test/async_fifo_tb.sv
`default_nettype none

`include "async_fifo_settings.svh"

module async_fifo_tb;

  import async_fifo_pkg::*;

  localparam int DEPTH         = `ASYNC_FIFO_DEPTH;
  localparam int AFULL_LEVEL   = `ASYNC_FIFO_AFULL_LEVEL;
  localparam int AEMPTY_LEVEL  = `ASYNC_FIFO_AEMPTY_LEVEL;
  localparam int TIMEOUT       = 100;   // Cycles for any single wait
  localparam int SETTLE_CYCLES = 5;     // Pointer crossing and flag register, plus margin
  localparam int STREAM_WORDS  = 200;
  localparam int STREAM_LIMIT  = 4000;
  localparam int COUNT_STEPS [6] = '{1, 2, 3, 13, 14, 15};
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  fifo_data_t wr_data;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  fifo_data_t rd_data;
  logic       rd_valid;
  logic       full;
  logic       afull;
  logic       empty;
  logic       aempty;

  fifo_data_t  exp_q[$];  // Accepted writes not yet seen on rd_data
  logic [31:0] wr_lfsr;
  logic [31:0] rd_lfsr;
  int          pending_reads;
  int          words_read;
  int          value_errors;
  int          timeout_errors;
  int          other_errors;

  async_fifo async_fifo_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #2 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #3 rd_clk = ~rd_clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  task automatic report_flag(input string name, input logic expected, input logic actual);
    value_errors++;
    $display("[ERROR] t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
  endtask

  task automatic report_word(input string name, input fifo_data_t expected,
                             input fifo_data_t actual);
    value_errors++;
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic report_count(input string name, input int expected, input int actual);
    value_errors++;
    $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
  endtask

  task automatic check_flags(input logic exp_full, input logic exp_afull,
                             input logic exp_empty, input logic exp_aempty);
    if (full !== exp_full) report_flag("full", exp_full, full);
    if (afull !== exp_afull) report_flag("afull", exp_afull, afull);
    if (empty !== exp_empty) report_flag("empty", exp_empty, empty);
    if (aempty !== exp_aempty) report_flag("aempty", exp_aempty, aempty);
  endtask

  // full only moves on rising edges, so the falling-edge value decides acceptance
  task automatic write_cycle(input logic en, input fifo_data_t data, output logic accepted);
    @(negedge wr_clk);
    wr_en    = en;
    wr_data  = data;
    accepted = en && !full;
    if (accepted) begin
      exp_q.push_back(data);
    end
  endtask

  task automatic write_random(output logic accepted);
    logic [31:0] bits;
    draw_bits(wr_lfsr, `ASYNC_FIFO_DATA_WIDTH, bits);
    write_cycle(1'b1, bits[`ASYNC_FIFO_DATA_WIDTH-1:0], accepted);
  endtask

  task automatic write_idle();
    logic acc;
    write_cycle(1'b0, '0, acc);
  endtask

  // One popped word per rd_valid is compared against the oldest queued write
  task automatic collect_read();
    fifo_data_t expected;
    if (rd_valid) begin
      if (pending_reads == 0) begin
        other_errors++;
        $display("rd_valid was high at %0t with no read accepted before it", $time);
      end else if (exp_q.size() == 0) begin
        pending_reads--;
        other_errors++;
        $display("rd_valid at %0t but no written word was left to compare", $time);
      end else begin
        pending_reads--;
        words_read++;
        expected = exp_q.pop_front();
        if (rd_data !== expected) report_word("rd_data", expected, rd_data);
      end
    end
  endtask

  task automatic read_cycle(input logic en, output logic accepted);
    @(negedge rd_clk);
    collect_read();
    rd_en    = en;
    accepted = en && !empty;
    if (accepted) pending_reads++;
  endtask

  task automatic drain_reads();
    logic acc;
    int   n;
    n = 0;
    do begin
      read_cycle(1'b0, acc);
      n++;
    end while (pending_reads != 0 && n < TIMEOUT);
    if (pending_reads != 0) begin
      timeout_errors++;
      $display("Timed out waiting for rd_valid on %0d accepted reads", pending_reads);
    end
  endtask

  task automatic read_words(input int count);
    logic acc;
    int   done;
    int   n;
    done = 0;
    n    = 0;
    while (done < count && n < TIMEOUT) begin
      read_cycle(1'b1, acc);
      if (acc) done++;
      n++;
    end
    drain_reads();
    if (done < count) begin
      timeout_errors++;
      $display("Timed out after %0d of %0d reads were accepted", done, count);
    end
  endtask

  task automatic wait_empty(input logic level);
    logic acc;
    int   n;
    n = 0;
    while (empty !== level && n < TIMEOUT) begin
      read_cycle(1'b0, acc);
      n++;
    end
    if (empty !== level) begin
      timeout_errors++;
      $display("Timed out waiting for empty to become %0b", level);
    end
  endtask

  task automatic wait_wr_flag(input string name, input logic level);
    logic acc;
    logic flag;
    int   n;
    n    = 0;
    flag = (name == "afull") ? afull : full;
    while (flag !== level && n < TIMEOUT) begin
      write_cycle(1'b0, '0, acc);
      flag = (name == "afull") ? afull : full;
      n++;
    end
    if (flag !== level) begin
      timeout_errors++;
      $display("Timed out waiting for %s to become %0b", name, level);
    end
  endtask

  // Lets the last write pointer reach the read flags
  task automatic settle_crossing();
    logic acc;
    for (int i = 0; i < SETTLE_CYCLES; i++) begin
      read_cycle(1'b0, acc);
    end
  endtask

  task automatic check_after_reset();
    check_flags(1'b0, 1'b0, 1'b1, 1'b1);
    if (rd_valid !== 1'b0) report_flag("rd_valid", 1'b0, rd_valid);
  endtask

  task automatic write_then_read();
    logic acc;
    int   start;
    start = words_read;
    for (int i = 0; i < 10; i++) begin
      write_random(acc);
      if (!acc) begin
        other_errors++;
        $display("Write %0d was refused although the FIFO was not full", i);
      end
    end
    write_idle();
    wait_empty(1'b0);
    read_words(10);
    if (words_read - start != 10) report_count("words read", 10, words_read - start);
    if (empty !== 1'b1) report_flag("empty", 1'b1, empty);
  endtask

  task automatic fill_to_full();
    logic acc;
    int   accepted_words;
    int   start;
    int   n;
    accepted_words = 0;
    n              = 0;
    acc            = 1'b1;
    start          = words_read;
    while (acc && n < TIMEOUT) begin  // Stops at the first write refused by full
      write_random(acc);
      if (acc) accepted_words++;
      n++;
    end
    if (accepted_words != DEPTH) report_count("accepted writes", DEPTH, accepted_words);
    if (full !== 1'b1) report_flag("full", 1'b1, full);
    for (int i = 0; i < 3; i++) begin
      write_random(acc);
      if (acc) begin
        other_errors++;
        $display("A write was accepted while the FIFO was full at %0t", $time);
      end
    end
    write_idle();
    read_words(DEPTH);
    for (int i = 0; i < 4; i++) begin
      read_cycle(1'b1, acc);
      if (acc) begin
        other_errors++;
        $display("A read was accepted after all written words were taken");
      end
    end
    drain_reads();
    if (words_read - start != DEPTH) report_count("words read", DEPTH, words_read - start);
    wait_wr_flag("full", 1'b0);  // Read pointer has to cross back first
  endtask

  task automatic almost_flags();
    logic acc;
    logic exp_afull;
    logic exp_aempty;
    int   n;
    for (int t = 0; t < 6; t++) begin
      n = 0;
      while (exp_q.size() < COUNT_STEPS[t] && n < TIMEOUT) begin
        write_random(acc);
        n++;
      end
      write_idle();
      exp_afull  = (COUNT_STEPS[t] >= AFULL_LEVEL);
      exp_aempty = (COUNT_STEPS[t] <= AEMPTY_LEVEL);
      wait_empty(1'b0);
      settle_crossing();
      if (afull !== exp_afull) report_flag("afull", exp_afull, afull);
      if (aempty !== exp_aempty) report_flag("aempty", exp_aempty, aempty);
    end
    read_words(exp_q.size());
    wait_wr_flag("afull", 1'b0);
    check_flags(1'b0, 1'b0, 1'b1, 1'b1);
  endtask

  task automatic read_while_empty();
    logic acc;
    int   start;
    start = words_read;
    for (int i = 0; i < 5; i++) begin
      read_cycle(1'b1, acc);
      if (acc) begin
        other_errors++;
        $display("A read was accepted while the FIFO was empty at %0t", $time);
      end
      if (rd_valid !== 1'b0) report_flag("rd_valid", 1'b0, rd_valid);
    end
    drain_reads();
    write_random(acc);
    write_idle();
    wait_empty(1'b0);
    read_words(1);  // Data mismatch here would mean the read pointer slipped
    if (words_read - start != 1) report_count("words read", 1, words_read - start);
    if (empty !== 1'b1) report_flag("empty", 1'b1, empty);
  endtask

  task automatic streaming();
    int start;
    start = words_read;
    fork
      begin
        logic [31:0] gap;
        logic        acc;
        int          sent;
        int          n;
        sent = 0;
        n    = 0;
        while (sent < STREAM_WORDS && n < STREAM_LIMIT) begin
          draw_bits(wr_lfsr, 2, gap);
          if (gap[1:0] == 2'b00) begin
            write_cycle(1'b0, '0, acc);
          end else begin
            write_random(acc);
            if (acc) sent++;
          end
          n++;
        end
        write_idle();
        if (sent < STREAM_WORDS) begin
          timeout_errors++;
          $display("Timed out after %0d streamed writes", sent);
        end
      end
      begin
        logic [31:0] gap;
        logic        acc;
        int          got;
        int          n;
        got = 0;
        n   = 0;
        while (got < STREAM_WORDS && n < STREAM_LIMIT) begin
          draw_bits(rd_lfsr, 2, gap);
          read_cycle(gap[1:0] != 2'b00, acc);
          if (acc) got++;
          n++;
        end
        drain_reads();
        if (got < STREAM_WORDS) begin
          timeout_errors++;
          $display("Timed out after %0d streamed reads", got);
        end
      end
    join
    if (words_read - start != STREAM_WORDS) begin
      report_count("words read", STREAM_WORDS, words_read - start);
    end
    if (exp_q.size() != 0) report_count("words left over", 0, exp_q.size());
  endtask

  initial begin
    wr_en          = 1'b0;
    wr_data        = '0;
    rd_en          = 1'b0;
    wr_rst_n       = 1'b0;
    rd_rst_n       = 1'b0;
    wr_lfsr        = 32'hd0fe;
    rd_lfsr        = 32'hd0fe;
    pending_reads  = 0;
    words_read     = 0;
    value_errors   = 0;
    timeout_errors = 0;
    other_errors   = 0;

    repeat (16) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    @(negedge rd_clk);
    rd_rst_n = 1'b1;

    check_after_reset();
    write_then_read();
    fill_to_full();
    almost_flags();
    read_while_empty();
    streaming();

    $display("Errors: %0d value, %0d timeout, %0d other",
             value_errors, timeout_errors, other_errors);
    if (value_errors + timeout_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/async_fifo_pkg.sv
hdl/fifo_dual_port_ram.sv
hdl/gray_ptr_sync.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/async_fifo.sv
test/async_fifo_assertions.sv
test/async_fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dual-clock FIFO testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module async_fifo_tb \
  -f verilog.f \
  -o async_fifo_sim

./obj_dir/async_fifo_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
